//--- rtl/corebus_pkg.sv
// Core bus request definitions
package corebus_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Field widths
  // ~~~~~~~~~~~~~~~~~~~~
  localparam int ADDR_WIDTH = 8;  // Command address, one word.
  localparam int DATA_WIDTH = 16; // Data word.

  // Burst length field holds the word count minus one.
  localparam int LEN_WIDTH = 2;

  // ~~~~~~~~~~~~~~~~~~~~
  // Command opcodes
  // ~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [1:0] {
    CMD_NOP       = 2'd0, // No data follows.
    CMD_WRITE     = 2'd1, // Burst to the decoded target.
    CMD_BROADCAST = 2'd2  // Same burst into every target.
  } corebus_opcode;

  // ~~~~~~~~~~~~~~~~~~~~
  // Command channel payload
  // ~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    corebus_opcode         opcode;
    logic [ADDR_WIDTH-1:0] addr;
    logic [LEN_WIDTH-1:0]  len;
  } corebus_command;

endpackage

//--- rtl/fabric_cfg_pkg.sv
// Register fabric layout
package fabric_cfg_pkg;

  localparam int INITIATORS = 2;
  localparam int TARGETS    = 4;

  // Address bits 5:4 pick the target, the upper bits are ignored.
  localparam int SELECT_WIDTH = 2;
  localparam int SELECT_LSB   = 4;

  // Address bits 1:0 give the first register of a burst.
  localparam int REGS_PER_TARGET = 4;

  localparam int INIT_SEL_WIDTH = $clog2(INITIATORS);
  localparam int REG_SEL_WIDTH  = $clog2(REGS_PER_TARGET);

endpackage

//--- rtl/corebus_request_if.sv
// Core bus request interface
`timescale 1ns/10ps

interface corebus_request_if;
  import corebus_pkg::*;

  // Command channel.
  logic           mcmd_valid;
  logic           scmd_accept;
  corebus_command mcmd;

  // Data channel.
  logic                  mdata_valid;
  logic                  sdata_accept;
  logic [DATA_WIDTH-1:0] mdata;
  logic                  mdata_last; // Set on the final word only.

  modport initiator (
    output mcmd_valid,
    output mcmd,
    output mdata_valid,
    output mdata,
    output mdata_last,
    input  scmd_accept,
    input  sdata_accept
  );

  modport target (
    input  mcmd_valid,
    input  mcmd,
    input  mdata_valid,
    input  mdata,
    input  mdata_last,
    output scmd_accept,
    output sdata_accept
  );

endinterface

//--- rtl/corebus_request_arbiter.sv
// Core bus request arbiter
`timescale 1ns/10ps

module corebus_request_arbiter (
  input logic                  i_clk,
  input logic                  i_rst_n,
  corebus_request_if.target    init_if [fabric_cfg_pkg::INITIATORS],
  corebus_request_if.initiator bus_if
);
  import corebus_pkg::*;
  import fabric_cfg_pkg::*;

  logic [INITIATORS-1:0] cmd_req;
  logic [INITIATORS-1:0] data_req;
  logic [INITIATORS-1:0] data_last;
  corebus_command        cmd_in  [INITIATORS];
  logic [DATA_WIDTH-1:0] data_in [INITIATORS];

  logic                      busy;
  logic                      active;
  logic                      pick_valid;
  logic [INIT_SEL_WIDTH-1:0] pick_idx;
  logic [INIT_SEL_WIDTH-1:0] busy_idx;
  logic [INIT_SEL_WIDTH-1:0] last_idx;
  logic [INIT_SEL_WIDTH-1:0] cur_idx;
  logic                      cmd_ack;
  logic                      last_ack;

  for (genvar i = 0; i < INITIATORS; i++) begin : g_init
    assign cmd_req[i]   = init_if[i].mcmd_valid;
    assign cmd_in[i]    = init_if[i].mcmd;
    assign data_req[i]  = init_if[i].mdata_valid;
    assign data_in[i]   = init_if[i].mdata;
    assign data_last[i] = init_if[i].mdata_last;

    // Accepts go back to the granted initiator only.
    assign init_if[i].scmd_accept  = bus_if.mcmd_valid && (pick_idx == INIT_SEL_WIDTH'(i)) &&
                                     bus_if.scmd_accept;
    assign init_if[i].sdata_accept = active && (cur_idx == INIT_SEL_WIDTH'(i)) &&
                                     bus_if.sdata_accept;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Round robin pick
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb begin : pick
    int cand;
    pick_valid = 1'b0;
    pick_idx   = last_idx;
    for (int k = 1; k <= INITIATORS; k++) begin
      cand = (int'(last_idx) + k) % INITIATORS; // Start after the last winner.
      if (!pick_valid && cmd_req[cand]) begin
        pick_valid = 1'b1;
        pick_idx   = INIT_SEL_WIDTH'(cand);
      end
    end
  end

  assign active  = busy || pick_valid;
  assign cur_idx = busy ? busy_idx : pick_idx;

  assign bus_if.mcmd_valid  = !busy && pick_valid; // Next command waits for the data.
  assign bus_if.mcmd        = cmd_in[cur_idx];
  assign bus_if.mdata_valid = active && data_req[cur_idx];
  assign bus_if.mdata       = data_in[cur_idx];
  assign bus_if.mdata_last  = data_last[cur_idx];

  assign cmd_ack  = bus_if.mcmd_valid && bus_if.scmd_accept;
  assign last_ack = bus_if.mdata_valid && bus_if.sdata_accept && bus_if.mdata_last;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy     <= 1'b0;
      busy_idx <= '0;
      last_idx <= INIT_SEL_WIDTH'(INITIATORS - 1); // Initiator 0 wins the first tie.
    end else begin
      if (cmd_ack) begin
        busy_idx <= pick_idx;
        last_idx <= pick_idx;
      end
      if (last_ack) begin
        busy <= 1'b0;
      end else if (cmd_ack && (bus_if.mcmd.opcode != CMD_NOP)) begin
        busy <= 1'b1;
      end
    end
  end

  // An opened burst locks the path to the initiator that sent its command.
  a_grant_locked : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (cmd_ack && !last_ack && (bus_if.mcmd.opcode != CMD_NOP)) |=>
      (busy && (cur_idx == $past(pick_idx))));

  // Downstream takes data only inside a granted burst.
  a_data_in_burst : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (bus_if.mdata_valid && bus_if.sdata_accept) |-> (busy || cmd_ack));

endmodule

//--- rtl/corebus_request_switch.sv
// Core bus request switch
`timescale 1ns/10ps

module corebus_request_switch (
  input logic                  i_clk,
  input logic                  i_rst_n,
  corebus_request_if.target    up_if,
  corebus_request_if.initiator down_if [fabric_cfg_pkg::TARGETS]
);
  import corebus_pkg::*;
  import fabric_cfg_pkg::*;

  logic [SELECT_WIDTH-1:0] select_in;
  logic [TARGETS-1:0]      command_mask;
  logic [TARGETS-1:0]      command_active;
  logic [TARGETS-1:0]      command_done;
  logic [TARGETS-1:0]      command_accept;
  logic [TARGETS-1:0]      data_accept;
  logic [TARGETS-1:0]      data_select;
  logic [TARGETS-1:0]      select_latched;
  logic                    up_cmd_ack;
  logic                    up_data_ack;

  // ~~~~~~~~~~~~~~~~~~~~
  // Address decode
  // ~~~~~~~~~~~~~~~~~~~~
  assign select_in = up_if.mcmd.addr[SELECT_LSB+:SELECT_WIDTH];

  always_comb begin
    for (int i = 0; i < TARGETS; i++) begin
      case (up_if.mcmd.opcode)
        CMD_WRITE:     command_mask[i] = (select_in == SELECT_WIDTH'(i));
        CMD_BROADCAST: command_mask[i] = 1'b1;
        default:       command_mask[i] = 1'b0; // NOP is absorbed here.
      endcase
    end
  end

  // Targets that took a broadcast already are not offered it again.
  assign command_active = command_mask & ~command_done;

  assign up_if.scmd_accept = &(command_accept | ~command_active);
  assign up_cmd_ack        = up_if.mcmd_valid && up_if.scmd_accept;

  // Decoded select in the command cycle, latched select afterwards.
  assign data_select = up_cmd_ack ? command_mask : select_latched;

  assign up_if.sdata_accept = (|data_select) && (&(data_accept | ~data_select));
  assign up_data_ack        = up_if.mdata_valid && up_if.sdata_accept;

  for (genvar i = 0; i < TARGETS; i++) begin : g_route
    assign down_if[i].mcmd_valid  = up_if.mcmd_valid && command_active[i];
    assign down_if[i].mcmd        = up_if.mcmd;
    assign down_if[i].mdata_valid = up_if.mdata_valid && data_select[i];
    assign down_if[i].mdata       = up_if.mdata;
    assign down_if[i].mdata_last  = up_if.mdata_last;
    assign command_accept[i]      = down_if[i].scmd_accept;
    assign data_accept[i]         = down_if[i].sdata_accept;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      command_done   <= '0;
      select_latched <= '0;
    end else begin
      if (up_cmd_ack) begin
        command_done <= '0;
      end else if (up_if.mcmd_valid) begin
        command_done <= command_done | (command_active & command_accept);
      end

      if (up_data_ack && up_if.mdata_last) begin
        select_latched <= '0; // Burst closed.
      end else if (up_cmd_ack) begin
        select_latched <= command_mask;
      end
    end
  end

  // An open burst holds a one-hot or all-ones select and lets no command through.
  a_select_shape : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (|select_latched) |-> (!up_cmd_ack && ($onehot(select_latched) || (&select_latched))));

  // Data with no open burst must be waiting behind its own command.
  a_no_stray_data : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (up_if.mdata_valid && !(|data_select)) |-> up_if.mcmd_valid);

endmodule

//--- rtl/csr_target.sv
// Control register target
`timescale 1ns/10ps

module csr_target (
  input  logic                                i_clk,
  input  logic                                i_rst_n,
  input  logic                                i_hold,
  corebus_request_if.target                   req_if,
  output logic [corebus_pkg::DATA_WIDTH-1:0] o_regs [fabric_cfg_pkg::REGS_PER_TARGET]
);
  import corebus_pkg::*;
  import fabric_cfg_pkg::*;

  logic                     busy;
  logic                     cmd_ack;
  logic                     data_ack;
  logic [REG_SEL_WIDTH-1:0] reg_idx;
  logic [REG_SEL_WIDTH-1:0] wr_idx;
  logic [LEN_WIDTH-1:0]     beat_cnt;
  logic [LEN_WIDTH-1:0]     beat_len;
  logic [LEN_WIDTH-1:0]     cur_cnt;
  logic [LEN_WIDTH-1:0]     cur_len;

  assign req_if.scmd_accept  = !busy && !i_hold;
  assign cmd_ack             = req_if.mcmd_valid && req_if.scmd_accept;
  assign req_if.sdata_accept = busy || cmd_ack; // First word may ride with the command.
  assign data_ack            = req_if.mdata_valid && req_if.sdata_accept;

  // Burst position, taken from the command while it is being accepted.
  assign wr_idx  = busy ? reg_idx : req_if.mcmd.addr[REG_SEL_WIDTH-1:0];
  assign cur_cnt = busy ? beat_cnt : '0;
  assign cur_len = busy ? beat_len : req_if.mcmd.len;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy     <= 1'b0;
      reg_idx  <= '0;
      beat_cnt <= '0;
      beat_len <= '0;
    end else begin
      if (cmd_ack) begin
        beat_len <= req_if.mcmd.len;
      end
      if (data_ack) begin
        busy     <= !req_if.mdata_last;
        reg_idx  <= wr_idx + REG_SEL_WIDTH'(1); // Wraps inside the target.
        beat_cnt <= cur_cnt + LEN_WIDTH'(1);
      end else if (cmd_ack) begin
        busy     <= 1'b1;
        reg_idx  <= wr_idx;
        beat_cnt <= '0;
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int r = 0; r < REGS_PER_TARGET; r++) begin
        o_regs[r] <= '0;
      end
    end else if (data_ack) begin
      o_regs[wr_idx] <= req_if.mdata;
    end
  end

  a_last_on_count : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    data_ack |-> (req_if.mdata_last == (cur_cnt == cur_len)));

endmodule

//--- rtl/corebus_fabric_top.sv
// Control register fabric
`timescale 1ns/10ps

module corebus_fabric_top (
  input  logic                                  i_clk,
  input  logic                                  i_rst_n,
  input  logic                                  i_cmd_valid_0,
  output logic                                  o_cmd_accept_0,
  input  corebus_pkg::corebus_opcode            i_cmd_opcode_0,
  input  logic [corebus_pkg::ADDR_WIDTH-1:0]    i_cmd_addr_0,
  input  logic [corebus_pkg::LEN_WIDTH-1:0]     i_cmd_len_0,
  input  logic                                  i_data_valid_0,
  output logic                                  o_data_accept_0,
  input  logic [corebus_pkg::DATA_WIDTH-1:0]    i_data_0,
  input  logic                                  i_data_last_0,
  input  logic                                  i_cmd_valid_1,
  output logic                                  o_cmd_accept_1,
  input  corebus_pkg::corebus_opcode            i_cmd_opcode_1,
  input  logic [corebus_pkg::ADDR_WIDTH-1:0]    i_cmd_addr_1,
  input  logic [corebus_pkg::LEN_WIDTH-1:0]     i_cmd_len_1,
  input  logic                                  i_data_valid_1,
  output logic                                  o_data_accept_1,
  input  logic [corebus_pkg::DATA_WIDTH-1:0]    i_data_1,
  input  logic                                  i_data_last_1,
  input  logic [fabric_cfg_pkg::TARGETS-1:0]    i_hold,
  output logic [fabric_cfg_pkg::TARGETS*fabric_cfg_pkg::REGS_PER_TARGET*
                corebus_pkg::DATA_WIDTH-1:0]    o_regs
);
  import corebus_pkg::*;
  import fabric_cfg_pkg::*;

  corebus_request_if init_if [INITIATORS] ();
  corebus_request_if bus_if ();
  corebus_request_if tgt_if [TARGETS] ();

  logic [DATA_WIDTH-1:0] target_regs [TARGETS][REGS_PER_TARGET];

  // ~~~~~~~~~~~~~~~~~~~~
  // Initiator ports
  // ~~~~~~~~~~~~~~~~~~~~
  assign init_if[0].mcmd_valid  = i_cmd_valid_0;
  assign init_if[0].mcmd        = '{i_cmd_opcode_0, i_cmd_addr_0, i_cmd_len_0};
  assign init_if[0].mdata_valid = i_data_valid_0;
  assign init_if[0].mdata       = i_data_0;
  assign init_if[0].mdata_last  = i_data_last_0;
  assign o_cmd_accept_0         = init_if[0].scmd_accept;
  assign o_data_accept_0        = init_if[0].sdata_accept;

  assign init_if[1].mcmd_valid  = i_cmd_valid_1;
  assign init_if[1].mcmd        = '{i_cmd_opcode_1, i_cmd_addr_1, i_cmd_len_1};
  assign init_if[1].mdata_valid = i_data_valid_1;
  assign init_if[1].mdata       = i_data_1;
  assign init_if[1].mdata_last  = i_data_last_1;
  assign o_cmd_accept_1         = init_if[1].scmd_accept;
  assign o_data_accept_1        = init_if[1].sdata_accept;

  corebus_request_arbiter u_arbiter (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .init_if (init_if),
    .bus_if  (bus_if)
  );

  corebus_request_switch u_switch (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .up_if   (bus_if),
    .down_if (tgt_if)
  );

  for (genvar t = 0; t < TARGETS; t++) begin : g_target
    csr_target u_target (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_hold  (i_hold[t]),
      .req_if  (tgt_if[t]),
      .o_regs  (target_regs[t])
    );

    // Target 0 register 0 sits in the lowest bits.
    for (genvar r = 0; r < REGS_PER_TARGET; r++) begin : g_reg
      assign o_regs[(t*REGS_PER_TARGET + r)*DATA_WIDTH +: DATA_WIDTH] = target_regs[t][r];
    end
  end

endmodule

//--- tb/tb_top.sv
// Register fabric testbench
`timescale 1ns/10ps

module tb_top;
  import corebus_pkg::*;
  import fabric_cfg_pkg::*;

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_BURSTS   = 17; // 8 target writes, 2 broadcasts, 1 held, 6 contention.
  localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_BURSTS * 50) * 2 * HALF_PERIOD;

  typedef logic [DATA_WIDTH-1:0] burst_words_t [4];

  logic                                          i_clk;
  logic                                          i_rst_n;
  logic [INITIATORS-1:0]                         cmd_valid, cmd_accept;
  logic [INITIATORS-1:0]                         data_valid, data_accept, data_last;
  corebus_opcode                                 cmd_op [INITIATORS];
  logic [INITIATORS-1:0][ADDR_WIDTH-1:0]         cmd_addr;
  logic [INITIATORS-1:0][LEN_WIDTH-1:0]          cmd_len;
  logic [INITIATORS-1:0][DATA_WIDTH-1:0]         data;
  logic [TARGETS-1:0]                            hold;
  logic [TARGETS*REGS_PER_TARGET*DATA_WIDTH-1:0] regs_flat;

  logic [DATA_WIDTH-1:0] exp_regs [TARGETS][REGS_PER_TARGET]; // Reference register model.
  int                    error_count;
  int                    seed;
  int                    grant_log [$];

  corebus_fabric_top DUT (
    .i_clk (i_clk), .i_rst_n (i_rst_n),
    .i_cmd_valid_0 (cmd_valid[0]), .o_cmd_accept_0 (cmd_accept[0]),
    .i_cmd_opcode_0 (cmd_op[0]), .i_cmd_addr_0 (cmd_addr[0]), .i_cmd_len_0 (cmd_len[0]),
    .i_data_valid_0 (data_valid[0]), .o_data_accept_0 (data_accept[0]),
    .i_data_0 (data[0]), .i_data_last_0 (data_last[0]),
    .i_cmd_valid_1 (cmd_valid[1]), .o_cmd_accept_1 (cmd_accept[1]),
    .i_cmd_opcode_1 (cmd_op[1]), .i_cmd_addr_1 (cmd_addr[1]), .i_cmd_len_1 (cmd_len[1]),
    .i_data_valid_1 (data_valid[1]), .o_data_accept_1 (data_accept[1]),
    .i_data_1 (data[1]), .i_data_last_1 (data_last[1]),
    .i_hold (hold), .o_regs (regs_flat)
  );

  initial i_clk = 1'b0;
  always #HALF_PERIOD i_clk = ~i_clk;

  // ~~~~~~~~~~~~~~~~~~~~
  // Compare tasks
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic compare_regs(input string name, input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_accept(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic compare_grant(input int got, input int exp);
    if (got != exp) begin
      error_count++;
      $display("Error at %0t: granted initiator is %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_all_regs();
    for (int t = 0; t < TARGETS; t++) begin
      for (int r = 0; r < REGS_PER_TARGET; r++) begin
        compare_regs($sformatf("o_regs[%0d][%0d]", t, r),
                     regs_flat[(t*REGS_PER_TARGET + r)*DATA_WIDTH +: DATA_WIDTH], exp_regs[t][r]);
      end
    end
  endtask

  // Bits 5:4 pick the target, bits 1:0 the first register, wrapping inside it.
  function automatic void apply_model(input corebus_opcode op, input logic [ADDR_WIDTH-1:0] addr,
                                      input logic [LEN_WIDTH-1:0] len, input burst_words_t words);
    int tgt;
    int start;
    tgt   = (int'(addr) >> 4) % 4;
    start = int'(addr) % 4;
    for (int t = 0; t < TARGETS; t++) begin
      if (op == CMD_BROADCAST || (op == CMD_WRITE && t == tgt)) begin
        for (int w = 0; w <= int'(len); w++) begin
          exp_regs[t][(start + w) % 4] = words[w];
        end
      end
    end
  endfunction

  task automatic fill_words(output burst_words_t words);
    for (int i = 0; i < 4; i++) begin
      words[i] = DATA_WIDTH'($random(seed));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Burst drivers
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic run_burst(input int init, input corebus_opcode op,
                           input logic [ADDR_WIDTH-1:0] addr, input logic [LEN_WIDTH-1:0] len,
                           input burst_words_t words);
    int   w;
    logic cmd_open;
    @(negedge i_clk);
    cmd_valid[init]  = 1'b1;
    cmd_op[init]     = op;
    cmd_addr[init]   = addr;
    cmd_len[init]    = len;
    data_valid[init] = 1'b1; // First word rides with the command.
    data[init]       = words[0];
    data_last[init]  = (len == '0);
    cmd_open = 1'b1;
    w        = 0;
    while (w <= int'(len)) begin
      #1;
      if (cmd_open && cmd_accept[init]) begin
        cmd_open = 1'b0;
        grant_log.push_back(init);
        apply_model(op, addr, len, words); // Bursts are serialized, so grant order is write order.
      end else if (cmd_open) begin
        // No word may pass ahead of its command.
        compare_accept($sformatf("o_data_accept_%0d", init), data_accept[init], 1'b0);
      end
      if (!cmd_open && data_accept[init]) begin
        w++;
      end
      @(negedge i_clk);
      if (!cmd_open) begin
        cmd_valid[init] = 1'b0;
      end
      if (w <= int'(len)) begin
        data[init]      = words[w];
        data_last[init] = (w == int'(len));
      end
    end
    data_valid[init] = 1'b0;
    data_last[init]  = 1'b0;
  endtask

  task automatic burst_under_hold(input int init, input corebus_opcode op,
                                  input logic [ADDR_WIDTH-1:0] addr,
                                  input logic [LEN_WIDTH-1:0] len,
                                  input burst_words_t words, input int held);
    @(negedge i_clk);
    hold[held] = 1'b1;
    fork
      run_burst(init, op, addr, len, words);
      begin
        repeat (6) @(negedge i_clk);
        #2;
        compare_accept($sformatf("o_cmd_accept_%0d", init), cmd_accept[init], 1'b0);
        check_all_regs(); // Nothing written while held.
        @(negedge i_clk);
        hold[held] = 1'b0;
      end
    join
    check_all_regs();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic verify_reset_state();
    check_all_regs();
    for (int i = 0; i < INITIATORS; i++) begin
      compare_accept($sformatf("o_cmd_accept_%0d", i), cmd_accept[i], 1'b0);
    end
  endtask

  task automatic write_each_target();
    burst_words_t w;
    for (int t = 0; t < TARGETS; t++) begin
      fill_words(w);
      run_burst(t % INITIATORS, CMD_WRITE, ADDR_WIDTH'((t << 4) | t), 2'd0, w);
      check_all_regs();
      fill_words(w);
      // Upper address bits set, start at register 3 to force the wrap.
      run_burst((t + 1) % INITIATORS, CMD_WRITE, ADDR_WIDTH'(8'h88 | (t << 4) | 3), 2'd3, w);
      check_all_regs();
    end
  endtask

  task automatic broadcast_writes();
    burst_words_t w;
    fill_words(w);
    run_burst(0, CMD_BROADCAST, 8'h01, 2'd2, w);
    check_all_regs();
    fill_words(w);
    burst_under_hold(1, CMD_BROADCAST, 8'h02, 2'd3, w, 3);
  endtask

  task automatic hold_then_release();
    burst_words_t w;
    fill_words(w);
    burst_under_hold(0, CMD_WRITE, 8'h12, 2'd1, w, 1);
  endtask

  task automatic contend_both_initiators();
    burst_words_t w0, w1;
    int prev;
    for (int round = 0; round < 3; round++) begin
      fill_words(w0);
      fill_words(w1);
      prev = (grant_log.size() > 0) ? grant_log[grant_log.size()-1] : INITIATORS - 1;
      fork
        run_burst(0, CMD_WRITE, 8'h20, 2'd3, w0);
        run_burst(1, CMD_WRITE, 8'h20, 2'd3, w1);
      join
      compare_grant(grant_log[grant_log.size()-2], 1 - prev);
      compare_grant(grant_log[grant_log.size()-1], prev);
      check_all_regs(); // Later burst owns all four registers, in order.
    end
  endtask

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("sim failed");
    $finish;
  end

  initial begin
    error_count = 0;
    seed        = 59933;
    i_rst_n     = 1'b0;
    cmd_valid   = '0;
    data_valid  = '0;
    data_last   = '0;
    cmd_addr    = '0;
    cmd_len     = '0;
    data        = '0;
    hold        = '0;
    for (int i = 0; i < INITIATORS; i++) begin
      cmd_op[i] = CMD_NOP;
    end
    for (int t = 0; t < TARGETS; t++) begin
      for (int r = 0; r < REGS_PER_TARGET; r++) begin
        exp_regs[t][r] = '0;
      end
    end
    repeat (RESET_CYCLES) @(negedge i_clk);
    i_rst_n = 1'b1;
    @(negedge i_clk);
    #1;
    verify_reset_state();
    write_each_target();
    broadcast_writes();
    hold_then_release();
    contend_both_initiators();
    $display("Errors: %0d", error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- compile.f
rtl/corebus_pkg.sv
rtl/fabric_cfg_pkg.sv
rtl/corebus_request_if.sv
rtl/corebus_request_arbiter.sv
rtl/corebus_request_switch.sv
rtl/csr_target.sv
rtl/corebus_fabric_top.sv
tb/tb_top.sv

//--- Makefile
# Verilator flow for the register fabric testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top -Mdir obj_dir -f compile.f

run: compile
	./obj_dir/Vtb_top | tee $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
